// ==== hw/mipsIsaPkg.sv ====
`default_nettype none

package mipsIsaPkg;

    typedef logic [31:0] wordT;     // data, address or instruction word
    typedef logic [4:0]  regAddrT;  // gpr number
    typedef logic [5:0]  opcodeT;   // instr[31:26]
    typedef logic [5:0]  functT;    // instr[5:0] of r-type

    //////////////////////////////////////////////////
    // primary opcodes
    localparam opcodeT opSpecial = 6'h00;  // r-type, decoded by funct
    localparam opcodeT opJ       = 6'h02;
    localparam opcodeT opBeq     = 6'h04;
    localparam opcodeT opOri     = 6'h0d;
    localparam opcodeT opLui     = 6'h0f;
    localparam opcodeT opLw      = 6'h23;
    localparam opcodeT opSw      = 6'h2b;

    // function codes under opSpecial
    localparam functT fnAddu = 6'h21;
    localparam functT fnSubu = 6'h23;
    localparam functT fnOr   = 6'h25;
    localparam functT fnSlt  = 6'h2a;

endpackage

`default_nettype wire

// ==== hw/pipeCtrlPkg.sv ====
`default_nettype none

package pipeCtrlPkg;

    typedef logic [2:0] aluOpT;
    localparam aluOpT aluAdd = 3'd0;
    localparam aluOpT aluSub = 3'd1;
    localparam aluOpT aluOr  = 3'd2;
    localparam aluOpT aluSlt = 3'd3;   // signed compare
    localparam aluOpT aluLui = 3'd4;   // operand b shifted up 16

    typedef logic [1:0] fwdSelT;
    localparam fwdSelT fwdReg = 2'd0;  // value read in decode
    localparam fwdSelT fwdMem = 2'd1;
    localparam fwdSelT fwdWb  = 2'd2;

    typedef logic [1:0] hazTimeT;      // tuse / tnew in cycles
    localparam hazTimeT tuseNone = 2'd3;  // source field not read

    typedef logic wbSrcT;
    localparam wbSrcT wbAlu  = 1'b0;
    localparam wbSrcT wbLoad = 1'b1;

endpackage

`default_nettype wire

// ==== hw/instrDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instrDecoder
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;
(
    input  wordT    instr,
    output aluOpT   aluOp,
    output logic    aluSrcImm,
    output logic    zeroExt,
    output logic    regWrite,
    output logic    memWrite,
    output logic    isBranch,
    output logic    isJump,
    output wbSrcT   wbSrc,
    output regAddrT dest,
    output hazTimeT tuseA,
    output hazTimeT tuseB,
    output hazTimeT tnew
);

    opcodeT op;
    functT  fn;
    logic   writes;   // before the $0 filter

    assign op = instr[31:26];
    assign fn = instr[5:0];

    always_comb begin
        aluOp     = aluAdd;
        aluSrcImm = 1'b0;
        zeroExt   = 1'b0;
        writes    = 1'b0;
        memWrite  = 1'b0;
        isBranch  = 1'b0;
        isJump    = 1'b0;
        wbSrc     = wbAlu;
        dest      = instr[20:16];   // rt for i-type
        tuseA     = tuseNone;
        tuseB     = tuseNone;
        tnew      = 2'd0;
        case (op)
            opSpecial: begin
                dest = instr[15:11];
                if (fn inside {fnAddu, fnSubu, fnOr, fnSlt}) begin
                    writes = 1'b1;
                    tuseA  = 2'd1;
                    tuseB  = 2'd1;
                    tnew   = 2'd1;
                end
                case (fn)
                    fnSubu:  aluOp = aluSub;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    default: aluOp = aluAdd;
                endcase
            end
            opOri: begin
                aluOp = aluOr; aluSrcImm = 1'b1; zeroExt = 1'b1;
                writes = 1'b1; tuseA = 2'd1; tnew = 2'd1;
            end
            opLui: begin
                aluOp = aluLui; aluSrcImm = 1'b1; zeroExt = 1'b1;
                writes = 1'b1; tnew = 2'd1;   // rs field unused
            end
            opLw: begin
                aluSrcImm = 1'b1; wbSrc = wbLoad;
                writes = 1'b1; tuseA = 2'd1; tnew = 2'd2;
            end
            opSw: begin
                aluSrcImm = 1'b1; memWrite = 1'b1;
                tuseA = 2'd1;
                tuseB = 2'd2;   // store data needed only in memory
            end
            opBeq: begin
                isBranch = 1'b1; tuseA = 2'd0; tuseB = 2'd0;
            end
            opJ:     isJump = 1'b1;
            default: ;   // nop or unsupported, no side effects
        endcase
    end

    assign regWrite = writes && (dest != '0);

endmodule

`default_nettype wire

// ==== hw/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regFile
    import mipsIsaPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    we,
    input  regAddrT raddrA,
    input  regAddrT raddrB,
    input  regAddrT waddr,
    input  wordT    wdata,
    output wordT    rdataA,
    output wordT    rdataB
);

    wordT regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // writeback in the same cycle wins over the stored copy
    assign rdataA = (raddrA == '0) ? '0 :
                    (we && (waddr == raddrA)) ? wdata : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 :
                    (we && (waddr == raddrB)) ? wdata : regs[raddrB];

endmodule

`default_nettype wire

// ==== hw/fetchStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetchStage
    import mipsIsaPkg::*;
#(
    parameter wordT resetPc = 32'h0000_3000
) (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic branchTaken,
    input  logic jumpTaken,
    input  wordT branchTarget,
    input  wordT jumpTarget,
    input  wordT instrData,
    output wordT instrAddr,
    output wordT instrD,
    output wordT pcD
);

    wordT pc;
    wordT nextPc;

    assign instrAddr = pc;
    // decode redirects only after the delay slot has been fetched
    assign nextPc = branchTaken ? branchTarget :
                    jumpTaken   ? jumpTarget   : pc + 32'd4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc     <= resetPc;
            instrD <= '0;   // sll $0 acts as bubble
            pcD    <= '0;
        end else if (!stall) begin
            pc     <= nextPc;
            instrD <= instrData;
            pcD    <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== hw/decodeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decodeStage
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,
    input  wordT    instrD,
    input  wordT    pcD,
    input  wordT    memResult,
    input  wordT    wbData,
    input  logic    wbWe,
    input  regAddrT wbAddr,
    input  fwdSelT  fwdA,
    input  fwdSelT  fwdB,
    output logic    branchTaken,
    output logic    jumpTaken,
    output wordT    branchTarget,
    output wordT    jumpTarget,
    output regAddrT rsD,
    output regAddrT rtD,
    output hazTimeT tuseA,
    output hazTimeT tuseB,
    output regAddrT rsE,
    output regAddrT rtE,
    output regAddrT destE,
    output logic    regWriteE,
    output hazTimeT tnewE,
    output aluOpT   aluOpE,
    output logic    aluSrcImmE,
    output logic    zeroExtE,
    output logic    memWriteE,
    output wbSrcT   wbSrcE,
    output wordT    opAE,
    output wordT    opBE,
    output wordT    immE,
    output wordT    pcE
);

    aluOpT   aluOp;
    logic    aluSrcImm;
    logic    zeroExt;
    logic    regWrite;
    logic    memWrite;
    logic    isBranch;
    logic    isJump;
    wbSrcT   wbSrc;
    regAddrT dest;
    hazTimeT tnew;
    wordT    rdataA;
    wordT    rdataB;
    wordT    valA;
    wordT    valB;
    wordT    pcPlus4;

    assign rsD = instrD[25:21];
    assign rtD = instrD[20:16];

    instrDecoder decoder (
        .instr(instrD), .aluOp, .aluSrcImm, .zeroExt, .regWrite, .memWrite,
        .isBranch, .isJump, .wbSrc, .dest, .tuseA, .tuseB, .tnew
    );

    regFile regs (
        .clk, .rstN, .we(wbWe), .raddrA(rsD), .raddrB(rtD),
        .waddr(wbAddr), .wdata(wbData), .rdataA, .rdataB
    );

    // writeback already reaches us through the regFile bypass
    assign valA = (fwdA == fwdMem) ? memResult : rdataA;
    assign valB = (fwdB == fwdMem) ? memResult : rdataB;

    //////////////////////////////////////////////////
    // branch and jump resolution
    assign pcPlus4      = pcD + 32'd4;
    assign branchTarget = pcPlus4 + {{14{instrD[15]}}, instrD[15:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], instrD[25:0], 2'b00};
    assign branchTaken  = isBranch && (valA == valB);
    assign jumpTaken    = isJump;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteE <= 1'b0;
            memWriteE <= 1'b0;
            destE     <= '0;
            tnewE     <= '0;
            rsE       <= '0;
            rtE       <= '0;
        end else begin
            regWriteE <= regWrite && !stall;   // stall inserts a bubble
            memWriteE <= memWrite && !stall;
            destE     <= dest;
            tnewE     <= tnew;
            rsE       <= rsD;
            rtE       <= rtD;
        end
    end

    always_ff @(posedge clk) begin
        aluOpE     <= aluOp;
        aluSrcImmE <= aluSrcImm;
        zeroExtE   <= zeroExt;
        wbSrcE     <= wbSrc;
        opAE       <= valA;
        opBE       <= valB;
        immE       <= {16'h0000, instrD[15:0]};   // extended in execute
        pcE        <= pcD;
    end

endmodule

`default_nettype wire

// ==== hw/hazardUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazardUnit
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;
(
    input  regAddrT rsD,
    input  regAddrT rtD,
    input  regAddrT rsE,
    input  regAddrT rtE,
    input  regAddrT rtM,
    input  regAddrT destE,
    input  regAddrT destM,
    input  regAddrT destW,
    input  hazTimeT tuseA,
    input  hazTimeT tuseB,
    input  hazTimeT tnewE,
    input  hazTimeT tnewM,
    input  logic    regWriteE,
    input  logic    regWriteM,
    input  logic    regWriteW,
    output logic    stall,
    output fwdSelT  fwdAD,
    output fwdSelT  fwdBD,
    output fwdSelT  fwdAE,
    output fwdSelT  fwdBE,
    output logic    fwdStoreM
);

    // producer writes src but its value comes later than src is needed
    function automatic logic waitsOn(regAddrT src, hazTimeT tuse, regAddrT dest,
                                     logic we, hazTimeT tnew);
        return we && (src != '0) && (src == dest) && (tnew > tuse);
    endfunction

    function automatic logic hits(regAddrT src, regAddrT dest, logic we);
        return we && (src != '0) && (src == dest);
    endfunction

    assign stall = waitsOn(rsD, tuseA, destE, regWriteE, tnewE) ||
                   waitsOn(rsD, tuseA, destM, regWriteM, tnewM) ||
                   waitsOn(rtD, tuseB, destE, regWriteE, tnewE) ||
                   waitsOn(rtD, tuseB, destM, regWriteM, tnewM);

    always_comb begin
        fwdAD = (hits(rsD, destM, regWriteM) && tnewM == '0) ? fwdMem : fwdReg;
        fwdBD = (hits(rtD, destM, regWriteM) && tnewM == '0) ? fwdMem : fwdReg;
        // a load still in memory is left to the writeback path
        fwdAE = (hits(rsE, destM, regWriteM) && tnewM == '0) ? fwdMem :
                hits(rsE, destW, regWriteW) ? fwdWb : fwdReg;
        fwdBE = (hits(rtE, destM, regWriteM) && tnewM == '0) ? fwdMem :
                hits(rtE, destW, regWriteW) ? fwdWb : fwdReg;
    end

    assign fwdStoreM = hits(rtM, destW, regWriteW);   // lw then sw of same reg

endmodule

`default_nettype wire

// ==== hw/executeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module executeStage
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  regAddrT rtE,
    input  regAddrT destE,
    input  logic    regWriteE,
    input  hazTimeT tnewE,
    input  aluOpT   aluOpE,
    input  logic    aluSrcImmE,
    input  logic    zeroExtE,
    input  logic    memWriteE,
    input  wbSrcT   wbSrcE,
    input  wordT    opAE,
    input  wordT    opBE,
    input  wordT    immE,
    input  wordT    pcE,
    input  fwdSelT  fwdA,
    input  fwdSelT  fwdB,
    input  wordT    memResult,
    input  wordT    wbData,
    output wordT    aluResultM,
    output wordT    storeDataM,
    output regAddrT rtM,
    output regAddrT destM,
    output logic    regWriteM,
    output logic    memWriteM,
    output wbSrcT   wbSrcM,
    output hazTimeT tnewM,
    output wordT    pcM
);

    wordT srcA;
    wordT regB;   // forwarded rt, also the store data
    wordT srcB;
    wordT extImm;
    wordT aluResult;

    function automatic wordT pickOperand(fwdSelT sel, wordT regVal, wordT memVal,
                                         wordT wbVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA   = pickOperand(fwdA, opAE, memResult, wbData);
    assign regB   = pickOperand(fwdB, opBE, memResult, wbData);
    assign extImm = zeroExtE ? {16'h0000, immE[15:0]} : {{16{immE[15]}}, immE[15:0]};
    assign srcB   = aluSrcImmE ? extImm : regB;

    always_comb begin
        case (aluOpE)
            aluAdd:  aluResult = srcA + srcB;
            aluSub:  aluResult = srcA - srcB;
            aluOr:   aluResult = srcA | srcB;
            aluSlt:  aluResult = wordT'($signed(srcA) < $signed(srcB));
            aluLui:  aluResult = {srcB[15:0], 16'h0000};
            default: aluResult = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteM <= 1'b0;
            memWriteM <= 1'b0;
            destM     <= '0;
            rtM       <= '0;
            tnewM     <= '0;
        end else begin
            regWriteM <= regWriteE;
            memWriteM <= memWriteE;
            destM     <= destE;
            rtM       <= rtE;
            tnewM     <= (tnewE != '0) ? tnewE - 2'd1 : '0;   // one stage closer
        end
    end

    always_ff @(posedge clk) begin
        aluResultM <= aluResult;
        storeDataM <= regB;
        wbSrcM     <= wbSrcE;
        pcM        <= pcE;
    end

endmodule

`default_nettype wire

// ==== hw/memoryStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module memoryStage
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  wordT       aluResultM,
    input  wordT       storeDataM,
    input  wordT       pcM,
    input  wordT       dataRdata,
    input  logic       regWriteM,
    input  logic       memWriteM,
    input  logic       fwdStore,
    input  wbSrcT      wbSrcM,
    input  regAddrT    destM,
    output wordT       dataAddr,
    output wordT       dataWdata,
    output wordT       memResult,
    output logic [3:0] dataByteen,
    output logic       grfWe,
    output regAddrT    grfAddr,
    output wordT       grfWdata,
    output wordT       wbPc
);

    wordT wbValue;

    assign dataAddr   = aluResultM;
    assign dataWdata  = fwdStore ? grfWdata : storeDataM;   // load right before store
    assign dataByteen = memWriteM ? 4'b1111 : 4'b0000;      // word stores only
    assign memResult  = aluResultM;

    // readback arrives in this cycle
    assign wbValue = (wbSrcM == wbLoad) ? dataRdata : aluResultM;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            grfWe   <= 1'b0;
            grfAddr <= '0;
        end else begin
            grfWe   <= regWriteM;
            grfAddr <= destM;
        end
    end

    always_ff @(posedge clk) begin
        grfWdata <= wbValue;
        wbPc     <= pcM;
    end

endmodule

`default_nettype wire

// ==== hw/cpuTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuTop
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;
#(
    parameter wordT resetPc = 32'h0000_3000
) (
    input  logic       clk,
    input  logic       rstN,
    input  wordT       instrData,
    input  wordT       dataRdata,
    output wordT       instrAddr,
    output wordT       dataAddr,
    output wordT       dataWdata,
    output wordT       wbPc,
    output wordT       grfWdata,
    output logic [3:0] dataByteen,
    output logic       grfWe,
    output regAddrT    grfAddr
);

    wordT    instrD, pcD, branchTarget, jumpTarget, memResult;
    wordT    opAE, opBE, immE, pcE, aluResultM, storeDataM, pcM;
    logic    stall, branchTaken, jumpTaken, fwdStoreM;
    logic    regWriteE, aluSrcImmE, zeroExtE, memWriteE, regWriteM, memWriteM;
    regAddrT rsD, rtD, rsE, rtE, destE, rtM, destM;
    hazTimeT tuseA, tuseB, tnewE, tnewM;
    aluOpT   aluOpE;
    wbSrcT   wbSrcE, wbSrcM;
    fwdSelT  fwdAD, fwdBD, fwdAE, fwdBE;

    fetchStage #(.resetPc(resetPc)) fetch (
        .clk, .rstN, .stall, .branchTaken, .jumpTaken, .branchTarget, .jumpTarget,
        .instrData, .instrAddr, .instrD, .pcD
    );

    decodeStage decode (
        .clk, .rstN, .stall, .instrD, .pcD, .memResult, .wbData(grfWdata),
        .wbWe(grfWe), .wbAddr(grfAddr), .fwdA(fwdAD), .fwdB(fwdBD),
        .branchTaken, .jumpTaken, .branchTarget, .jumpTarget, .rsD, .rtD, .tuseA, .tuseB,
        .rsE, .rtE, .destE, .regWriteE, .tnewE, .aluOpE, .aluSrcImmE, .zeroExtE,
        .memWriteE, .wbSrcE, .opAE, .opBE, .immE, .pcE
    );

    hazardUnit hazard (
        .rsD, .rtD, .rsE, .rtE, .rtM, .destE, .destM, .destW(grfAddr),
        .tuseA, .tuseB, .tnewE, .tnewM, .regWriteE, .regWriteM, .regWriteW(grfWe),
        .stall, .fwdAD, .fwdBD, .fwdAE, .fwdBE, .fwdStoreM
    );

    executeStage execute (
        .clk, .rstN, .rtE, .destE, .regWriteE, .tnewE, .aluOpE, .aluSrcImmE, .zeroExtE,
        .memWriteE, .wbSrcE, .opAE, .opBE, .immE, .pcE, .fwdA(fwdAE), .fwdB(fwdBE),
        .memResult, .wbData(grfWdata), .aluResultM, .storeDataM, .rtM, .destM,
        .regWriteM, .memWriteM, .wbSrcM, .tnewM, .pcM
    );

    memoryStage memory (
        .clk, .rstN, .aluResultM, .storeDataM, .pcM, .dataRdata, .regWriteM, .memWriteM,
        .fwdStore(fwdStoreM), .wbSrcM, .destM, .dataAddr, .dataWdata, .memResult,
        .dataByteen, .grfWe, .grfAddr, .grfWdata, .wbPc
    );

endmodule

`default_nettype wire

// ==== verification/cpuTop_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuTop_assertions
    import mipsIsaPkg::*;
(
    input logic       clk,
    input logic       rstN,
    input logic       grfWe,
    input regAddrT    grfAddr,
    input logic [3:0] dataByteen,
    input wordT       instrAddr
);

    int failCount = 0;   // read by the testbench

    // $0 is hardwired, decode must drop such writes
    noZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
        grfWe |-> (grfAddr != '0))
        else begin
            failCount++;
            $error("writeback targets register zero");
        end

    wordEnables: assert property (@(posedge clk) disable iff (!rstN)
        dataByteen inside {4'b0000, 4'b1111})
        else begin
            failCount++;
            $error("byte enables are neither idle nor a full word");
        end

    fetchAligned: assert property (@(posedge clk) disable iff (!rstN)
        instrAddr[1:0] == 2'b00)
        else begin
            failCount++;
            $error("fetch address is not word aligned");
        end

    // pipeline comes out of reset empty
    quietAfterReset: assert property (@(posedge clk)
        $rose(rstN) |-> (!grfWe && (dataByteen == 4'b0000)))
        else begin
            failCount++;
            $error("writeback or store active right after reset");
        end

endmodule

`default_nettype wire

// ==== verification/cpuTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuTb
    import mipsIsaPkg::*;
();

    localparam int progLen   = 20;
    localparam int wbLen     = 14;
    localparam int storeLen  = 2;
    localparam int romWords  = 64;
    localparam int waitLimit = 50;   // cycles per wait

    logic       clk;
    logic       rstN;
    wordT       instrData;
    wordT       dataRdata;
    wordT       instrAddr;
    wordT       dataAddr;
    wordT       dataWdata;
    wordT       wbPc;
    wordT       grfWdata;
    logic [3:0] dataByteen;
    logic       grfWe;
    regAddrT    grfAddr;

    wordT    rom [romWords];
    wordT    ram [16];
    wordT    romIndex;

    wordT    progWords [progLen];
    regAddrT wbRegs [wbLen];
    wordT    wbVals [wbLen];
    wordT    wbPcs [wbLen];
    wordT    storeAddrs [storeLen];
    wordT    storeData [storeLen];

    typedef struct packed {
        logic       isStore;
        wordT       key;   // register number or byte address
        wordT       val;
        wordT       pc;
        logic [3:0] en;
    } obsT;

    obsT obsQ [$];

    initial clk = 1'b0;
    always #2 clk = ~clk;

    cpuTop DUT (
        .clk, .rstN, .instrData, .dataRdata, .instrAddr, .dataAddr, .dataWdata,
        .wbPc, .grfWdata, .dataByteen, .grfWe, .grfAddr
    );

    bind cpuTop cpuTop_assertions checks (
        .clk, .rstN, .grfWe, .grfAddr, .dataByteen, .instrAddr
    );

    //////////////////////////////////////////////////
    // memory models
    assign romIndex  = (instrAddr - DUT.resetPc) >> 2;
    assign instrData = (romIndex < romWords) ? rom[romIndex[5:0]] : '0;   // nop outside
    assign dataRdata = ram[dataAddr[5:2]];

    always @(posedge clk) begin
        if (dataByteen == 4'b1111) begin
            ram[dataAddr[5:2]] <= dataWdata;
        end
    end

    //////////////////////////////////////////////////
    // instruction encoders
    function automatic wordT encR(functT fn, regAddrT rs, regAddrT rt, regAddrT rd);
        return {opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic wordT encI(opcodeT op, regAddrT rs, regAddrT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT encJ(wordT target);
        return {opJ, target[27:2]};
    endfunction

    task automatic putWriteback(int idx, regAddrT r, wordT v, int instrIdx);
        wbRegs[idx] = r;
        wbVals[idx] = v;
        wbPcs[idx]  = DUT.resetPc + wordT'(instrIdx * 4);
    endtask

    task automatic buildTables();
        wordT r1, r2, r3, r4, r5, r6, r7, r8, r9, r10, r11, r12, r13, r15;
        r1  = {16'h0000, 16'h1234};   // ori zero extends
        r2  = {16'h8000, 16'h0000};   // lui shifts up
        r3  = {16'h0000, 16'h0005};
        r4  = r1 + r3;
        r5  = r3 - r4;                // wraps below zero
        r6  = r4 | r2;
        r7  = 32'd1;                  // negative r5 below positive r4
        r8  = 32'd0;                  // r2 is the most negative word
        r9  = r6 + r6;                // carry out lost
        r10 = r9;                     // loaded back from address 8
        r11 = r10 + r1;
        r12 = r9;
        r13 = {16'h0000, 16'h80aa};
        r15 = {16'h0000, 16'h00cc};

        progWords[0]  = encI(opOri, 5'd0, 5'd1, 16'h1234);
        progWords[1]  = encI(opLui, 5'd0, 5'd2, 16'h8000);
        progWords[2]  = encI(opOri, 5'd0, 5'd3, 16'h0005);
        progWords[3]  = encR(fnAddu, 5'd1, 5'd3, 5'd4);
        progWords[4]  = encR(fnSubu, 5'd3, 5'd4, 5'd5);
        progWords[5]  = encR(fnOr, 5'd4, 5'd2, 5'd6);
        progWords[6]  = encR(fnSlt, 5'd5, 5'd4, 5'd7);
        progWords[7]  = encR(fnSlt, 5'd4, 5'd2, 5'd8);
        progWords[8]  = encR(fnAddu, 5'd6, 5'd6, 5'd9);
        progWords[9]  = encI(opSw, 5'd0, 5'd9, 16'h0008);
        progWords[10] = encI(opLw, 5'd0, 5'd10, 16'h0008);
        progWords[11] = encR(fnAddu, 5'd10, 5'd1, 5'd11);   // load-use
        progWords[12] = encI(opLw, 5'd0, 5'd12, 16'h0008);
        progWords[13] = encI(opSw, 5'd0, 5'd12, 16'h000c);  // store of fresh load
        progWords[14] = encI(opBeq, 5'd12, 5'd9, 16'h0002);
        progWords[15] = encI(opOri, 5'd0, 5'd13, 16'h80aa); // delay slot
        progWords[16] = encI(opOri, 5'd0, 5'd14, 16'h00bb); // skipped
        progWords[17] = encI(opOri, 5'd0, 5'd15, 16'h00cc); // branch target
        progWords[18] = encJ(DUT.resetPc + 32'd72);         // spin here
        progWords[19] = encI(opOri, 5'd0, 5'd0, 16'h0077);  // slot aims at $0

        putWriteback(0, 5'd1, r1, 0);
        putWriteback(1, 5'd2, r2, 1);
        putWriteback(2, 5'd3, r3, 2);
        putWriteback(3, 5'd4, r4, 3);
        putWriteback(4, 5'd5, r5, 4);
        putWriteback(5, 5'd6, r6, 5);
        putWriteback(6, 5'd7, r7, 6);
        putWriteback(7, 5'd8, r8, 7);
        putWriteback(8, 5'd9, r9, 8);
        putWriteback(9, 5'd10, r10, 10);
        putWriteback(10, 5'd11, r11, 11);
        putWriteback(11, 5'd12, r12, 12);
        putWriteback(12, 5'd13, r13, 15);
        putWriteback(13, 5'd15, r15, 17);

        storeAddrs[0] = 32'd8;
        storeData[0]  = r9;
        storeAddrs[1] = 32'd12;
        storeData[1]  = r12;

        for (int i = 0; i < romWords; i++) begin
            rom[i] = (i < progLen) ? progWords[i] : 32'h0000_0000;
        end
        for (int i = 0; i < 16; i++) begin
            ram[i] = 32'hd0d0_0000 | wordT'(i * 4);
        end
    endtask

    //////////////////////////////////////////////////
    // checks
    task automatic abortRun();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkWord(string name, wordT got, wordT exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkReg(string name, regAddrT got, regAddrT exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkEnable(string name, logic [3:0] got, logic [3:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkAssertions();
        if (DUT.checks.failCount != 0) begin
            $display("an assertion on the cpuTop ports failed at %0t ns", $time);
            abortRun();
        end
    endtask

    // writeback before store when both show in one cycle
    task automatic sampleCycle();
        obsT item;
        if (grfWe) begin
            item.isStore = 1'b0;
            item.key     = {27'd0, grfAddr};
            item.val     = grfWdata;
            item.pc      = wbPc;
            item.en      = dataByteen;
            obsQ.push_back(item);
        end
        if (dataByteen != 4'b0000) begin
            item.isStore = 1'b1;
            item.key     = dataAddr;
            item.val     = dataWdata;
            item.en      = dataByteen;
            obsQ.push_back(item);
        end
    endtask

    task automatic nextObserved(output obsT obs);
        int waited;
        waited = 0;
        while (obsQ.size() == 0) begin
            @(negedge clk);   // outputs settled
            waited++;
            checkAssertions();
            sampleCycle();
            if (obsQ.size() == 0 && waited >= waitLimit) begin
                $display("timeout: no writeback or store within %0d cycles", waitLimit);
                abortRun();
            end
        end
        obs = obsQ.pop_front();
    endtask

    // final j spins with an ori to $0 in its slot
    task automatic checkQuiet();
        for (int i = 0; i < waitLimit; i++) begin
            @(negedge clk);
            checkAssertions();
            if (grfWe || (dataByteen != 4'b0000)) begin
                $display("writeback or store seen after the final jump at %0t ns", $time);
                abortRun();
            end
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    initial begin
        obsT obs;
        int  wbIdx;
        int  stIdx;
        rstN  = 1'b0;
        wbIdx = 0;
        stIdx = 0;
        buildTables();
        repeat (5) @(posedge clk);
        rstN <= 1'b1;

        while (wbIdx < wbLen || stIdx < storeLen) begin
            nextObserved(obs);
            if (obs.isStore) begin
                if (stIdx >= storeLen) begin
                    $display("unexpected extra store to address %h", obs.key);
                    abortRun();
                end
                checkWord("dataAddr", obs.key, storeAddrs[stIdx]);
                checkWord("dataWdata", obs.val, storeData[stIdx]);
                checkEnable("dataByteen", obs.en, 4'b1111);
                stIdx++;
            end else begin
                if (wbIdx >= wbLen) begin
                    $display("unexpected extra writeback to register %0d", obs.key[4:0]);
                    abortRun();
                end
                checkReg("grfAddr", obs.key[4:0], wbRegs[wbIdx]);
                checkWord("grfWdata", obs.val, wbVals[wbIdx]);
                checkWord("wbPc", obs.pc, wbPcs[wbIdx]);
                wbIdx++;
            end
        end

        checkQuiet();
        if (DUT.checks.failCount == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("an assertion on the cpuTop ports failed during the run");
            abortRun();
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/mipsIsaPkg.sv
hw/pipeCtrlPkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/hazardUnit.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/cpuTop.sv
verification/cpuTop_assertions.sv
verification/cpuTb.sv
